// File: files.f
hdl/crossbarPkg.sv
hdl/inSpikeBuf.sv
hdl/synapseWeightMem.sv
hdl/recallUnit.sv
hdl/learnUnit.sv
hdl/coreController.sv
hdl/crossbarCore.sv
tests/tbClkGen.sv
tests/tbCrossbarCore.sv

// File: hdl/coreController.sv
/*
 * Core controller
 * Sequences recall sweep, pattern save and learn sweep,
 * one synapse per cycle, and reports busy and done to the host.
 */
`timescale 1ns/1ps
`default_nettype none

module coreController (
	input  wire                     clk_i,
	input  wire                     rst_n_i,
	input  wire                     start_i,
	input  wire                     fireValid_i,
	input  wire                     lrnDone_i,
	input  wire                     spikeWrEn_i,
	// Recall sweep
	output logic                    rclRdEn_o,
	output crossbarPkg::axonAddrT   rclAxon_o,
	output crossbarPkg::neuronAddrT rclNeuron_o,
	output logic                    rclLast_o,
	output logic                    saveRclSpikes_o,
	// Learn sweep
	output logic                    lrnRdEn_o,
	output crossbarPkg::axonAddrT   lrnAxon_o,
	output crossbarPkg::neuronAddrT lrnNeuron_o,
	output logic                    busy_o,
	output logic                    done_o
);

	crossbarPkg::ctrlStateT state;
	// Synapse counter shared by both sweeps
	crossbarPkg::synAddrT cnt;

	// ------------------------------------------------------------------------
	// Phase FSM
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state <= crossbarPkg::IDLE;
			cnt <= '0;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state)
				crossbarPkg::IDLE: begin
					if (start_i) begin
						state <= crossbarPkg::RECALL;
						cnt <= '0;
					end
				end
				crossbarPkg::RECALL: begin
					cnt <= cnt + crossbarPkg::synAddrT'(1);
					if (cnt == '1) begin
						state <= crossbarPkg::RECALL_WAIT;
					end
				end
				crossbarPkg::RECALL_WAIT: begin
					// Save goes out this cycle
					if (fireValid_i) begin
						state <= crossbarPkg::LEARN;
						cnt <= '0;
					end
				end
				crossbarPkg::LEARN: begin
					cnt <= cnt + crossbarPkg::synAddrT'(1);
					if (cnt == '1) begin
						state <= crossbarPkg::LEARN_WAIT;
					end
				end
				crossbarPkg::LEARN_WAIT: begin
					if (lrnDone_i) begin
						state <= crossbarPkg::IDLE;
						done_o <= 1'b1;
					end
				end
				default: begin
					state <= crossbarPkg::IDLE;
				end
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// Sweep outputs
	// ------------------------------------------------------------------------
	// Neuron in the upper counter bits, so axons run fastest
	assign rclRdEn_o = (state == crossbarPkg::RECALL);
	assign rclNeuron_o = cnt[crossbarPkg::SYN_W-1:crossbarPkg::AXON_W];
	assign rclAxon_o = cnt[crossbarPkg::AXON_W-1:0];
	assign rclLast_o = rclRdEn_o && (rclAxon_o == '1);
	assign saveRclSpikes_o = (state == crossbarPkg::RECALL_WAIT) && fireValid_i;

	assign lrnRdEn_o = (state == crossbarPkg::LEARN);
	assign lrnNeuron_o = cnt[crossbarPkg::SYN_W-1:crossbarPkg::AXON_W];
	assign lrnAxon_o = cnt[crossbarPkg::AXON_W-1:0];
	assign busy_o = (state != crossbarPkg::IDLE);

	// Host pattern writes must stay out of the recall phase
	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		spikeWrEn_i |-> (state != crossbarPkg::RECALL && state != crossbarPkg::RECALL_WAIT))
		else $error("spike write during recall");

endmodule

`default_nettype wire

// File: hdl/crossbarCore.sv
/*
 * Crossbar core top level
 * Spike buffer, weight memory, recall and learn units
 * and the phase controller of one crossbar core.
 */
`timescale 1ns/1ps
`default_nettype none

module crossbarCore (
	input  wire                   clk_i,
	input  wire                   rst_n_i,
	input  wire                   start_i,
	input  wire                   spikeWrEn_i,
	input  crossbarPkg::axonAddrT spikeAddr_i,
	input  wire                   spikeData_i,
	input  wire                   wtWrEn_i,
	input  wire                   wtRdEn_i,
	input  crossbarPkg::synAddrT  wtAddr_i,
	input  crossbarPkg::weightT   wtData_i,
	output crossbarPkg::weightT   wtRdData_o,
	output crossbarPkg::spikeVecT outSpikes_o,
	output logic                  busy_o,
	output logic                  done_o
);

	// ------------------------------------------------------------------------
	// Internal nets
	// ------------------------------------------------------------------------
	logic rclRdEn;
	logic rclLast;
	crossbarPkg::axonAddrT rclAxon;
	crossbarPkg::neuronAddrT rclNeuron;
	logic lrnRdEn;
	crossbarPkg::axonAddrT lrnAxon;
	crossbarPkg::neuronAddrT lrnNeuron;
	logic saveRclSpikes;
	logic rclSpike;
	logic lrnSpike;
	crossbarPkg::weightT rclWeight;
	crossbarPkg::weightT lrnWeight;
	logic fireValid;
	logic lrnWrEn;
	crossbarPkg::synAddrT lrnWrAddr;
	crossbarPkg::weightT lrnWrData;
	logic lrnDone;

	coreController i_ctrl (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.start_i(start_i),
		.fireValid_i(fireValid),
		.lrnDone_i(lrnDone),
		.spikeWrEn_i(spikeWrEn_i),
		.rclRdEn_o(rclRdEn),
		.rclAxon_o(rclAxon),
		.rclNeuron_o(rclNeuron),
		.rclLast_o(rclLast),
		.saveRclSpikes_o(saveRclSpikes),
		.lrnRdEn_o(lrnRdEn),
		.lrnAxon_o(lrnAxon),
		.lrnNeuron_o(lrnNeuron),
		.busy_o(busy_o),
		.done_o(done_o)
	);

	inSpikeBuf i_spikeBuf (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.spikeWrEn_i(spikeWrEn_i),
		.spikeAddr_i(spikeAddr_i),
		.spikeData_i(spikeData_i),
		.rclRdEn_i(rclRdEn),
		.rclAxonAddr_i(rclAxon),
		.saveRclSpikes_i(saveRclSpikes),
		.lrnRdEn_i(lrnRdEn),
		.lrnAxonAddr_i(lrnAxon),
		.rclSpike_o(rclSpike),
		.lrnSpike_o(lrnSpike)
	);

	// Synapse address is neuron then axon
	synapseWeightMem i_weights (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.rclRdEn_i(rclRdEn),
		.rclAddr_i({rclNeuron, rclAxon}),
		.rclWeight_o(rclWeight),
		.lrnRdEn_i(lrnRdEn),
		.lrnRdAddr_i({lrnNeuron, lrnAxon}),
		.lrnWeight_o(lrnWeight),
		.lrnWrEn_i(lrnWrEn),
		.lrnWrAddr_i(lrnWrAddr),
		.lrnWrData_i(lrnWrData),
		.hostWrEn_i(wtWrEn_i),
		.hostRdEn_i(wtRdEn_i),
		.hostAddr_i(wtAddr_i),
		.hostWrData_i(wtData_i),
		.hostRdData_o(wtRdData_o)
	);

	// Fire vector feeds learning and the host
	recallUnit i_recall (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.rdEn_i(rclRdEn),
		.last_i(rclLast),
		.neuron_i(rclNeuron),
		.spike_i(rclSpike),
		.weight_i(rclWeight),
		.fireVec_o(outSpikes_o),
		.fireValid_o(fireValid)
	);

	learnUnit i_learn (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.rdEn_i(lrnRdEn),
		.neuron_i(lrnNeuron),
		.axon_i(lrnAxon),
		.fireVec_i(outSpikes_o),
		.spike_i(lrnSpike),
		.weight_i(lrnWeight),
		.wrEn_o(lrnWrEn),
		.wrAddr_o(lrnWrAddr),
		.wrData_o(lrnWrData),
		.done_o(lrnDone)
	);

endmodule

`default_nettype wire

// File: hdl/crossbarPkg.sv
/*
 * Crossbar core shared definitions
 * Array sizes, vector types, the firing threshold, the weight limit
 * and the phase states of the core controller.
 */
`default_nettype none

package crossbarPkg;

	// ------------------------------------------------------------------------
	// Array sizes
	// ------------------------------------------------------------------------
	localparam int NUM_AXONS = 16;
	localparam int NUM_NEURONS = 4;
	localparam int NUM_SYN = NUM_AXONS * NUM_NEURONS;

	// Field widths
	localparam int AXON_W = $clog2(NUM_AXONS);
	localparam int NEURON_W = $clog2(NUM_NEURONS);
	localparam int SYN_W = NEURON_W + AXON_W;
	localparam int WEIGHT_W = 8;
	// Wide enough for 16 x 255
	localparam int POT_W = 12;

	typedef logic [AXON_W-1:0] axonAddrT;
	typedef logic [NEURON_W-1:0] neuronAddrT;
	// Neuron index in the upper bits, axon index below
	typedef logic [SYN_W-1:0] synAddrT;
	typedef logic [WEIGHT_W-1:0] weightT;
	typedef logic [POT_W-1:0] potentialT;
	typedef logic [NUM_NEURONS-1:0] spikeVecT;

	// Saturation ceiling and firing level
	localparam weightT WEIGHT_MAX = 8'd255;
	localparam potentialT THRESHOLD = 12'd200;

	// Controller phases
	typedef enum logic [2:0] {
		IDLE,
		RECALL,
		RECALL_WAIT,
		LEARN,
		LEARN_WAIT
	} ctrlStateT;

endpackage

`default_nettype wire

// File: hdl/inSpikeBuf.sv
/*
 * Input spike buffer
 * Recall copy written by the host, learn copy loaded in one cycle
 * from the recall copy, each with its own registered read port.
 */
`timescale 1ns/1ps
`default_nettype none

module inSpikeBuf (
	input  wire                   clk_i,
	input  wire                   rst_n_i,
	input  wire                   spikeWrEn_i,
	input  crossbarPkg::axonAddrT spikeAddr_i,
	input  wire                   spikeData_i,
	input  wire                   rclRdEn_i,
	input  crossbarPkg::axonAddrT rclAxonAddr_i,
	input  wire                   saveRclSpikes_i,
	input  wire                   lrnRdEn_i,
	input  crossbarPkg::axonAddrT lrnAxonAddr_i,
	output logic                  rclSpike_o,
	output logic                  lrnSpike_o
);

	// One bit per axon
	logic [crossbarPkg::NUM_AXONS-1:0] rclBuf;
	logic [crossbarPkg::NUM_AXONS-1:0] lrnBuf;

	// ------------------------------------------------------------------------
	// Buffers and read ports
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rclBuf <= '0;
			lrnBuf <= '0;
			rclSpike_o <= 1'b0;
			lrnSpike_o <= 1'b0;
		end else begin
			// Host load of the next pattern
			if (spikeWrEn_i) begin
				rclBuf[spikeAddr_i] <= spikeData_i;
			end
			// Freeze recall pattern for the learn sweep
			if (saveRclSpikes_i) begin
				lrnBuf <= rclBuf;
			end
			// Outputs hold when not read
			if (rclRdEn_i) begin
				rclSpike_o <= rclBuf[rclAxonAddr_i];
			end
			if (lrnRdEn_i) begin
				lrnSpike_o <= lrnBuf[lrnAxonAddr_i];
			end
		end
	end

	// Host may not load while the pattern is being saved
	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(spikeWrEn_i && saveRclSpikes_i))
		else $error("spike write during pattern save");

endmodule

`default_nettype wire

// File: hdl/learnUnit.sv
/*
 * Learn unit
 * Two-stage read-modify-write pipeline. Weights of fired neurons
 * step toward the saved pattern, saturating at both ends.
 */
`timescale 1ns/1ps
`default_nettype none

module learnUnit (
	input  wire                     clk_i,
	input  wire                     rst_n_i,
	input  wire                     rdEn_i,
	input  crossbarPkg::neuronAddrT neuron_i,
	input  crossbarPkg::axonAddrT   axon_i,
	input  crossbarPkg::spikeVecT   fireVec_i,
	input  wire                     spike_i,
	input  crossbarPkg::weightT     weight_i,
	output logic                    wrEn_o,
	output crossbarPkg::synAddrT    wrAddr_o,
	output crossbarPkg::weightT     wrData_o,
	output logic                    done_o
);

	// Stage 1 lined up with spike and weight
	logic valid1;
	crossbarPkg::neuronAddrT neuron1;
	crossbarPkg::axonAddrT axon1;
	// Stage 2 end-of-sweep marker
	logic last2;

	crossbarPkg::weightT newWeight;

	// Saturating step toward the pattern
	always_comb begin
		if (spike_i) begin
			newWeight = (weight_i == crossbarPkg::WEIGHT_MAX) ? weight_i : weight_i + 8'd1;
		end else begin
			newWeight = (weight_i == '0) ? weight_i : weight_i - 8'd1;
		end
	end

	// ------------------------------------------------------------------------
	// Pipeline control
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid1 <= 1'b0;
			neuron1 <= '0;
			axon1 <= '0;
			wrEn_o <= 1'b0;
			last2 <= 1'b0;
			done_o <= 1'b0;
		end else begin
			valid1 <= rdEn_i;
			neuron1 <= neuron_i;
			axon1 <= axon_i;
			// Silent neurons keep their weights
			wrEn_o <= valid1 && fireVec_i[neuron1];
			// Last synapse is neuron 3, axon 15
			last2 <= valid1 && (neuron1 == '1) && (axon1 == '1);
			done_o <= last2;
		end
	end

	// Write payload
	always_ff @(posedge clk_i) begin
		wrAddr_o <= {neuron1, axon1};
		wrData_o <= newWeight;
	end

endmodule

`default_nettype wire

// File: hdl/recallUnit.sv
/*
 * Recall unit
 * Sums the weights of active axons per neuron and compares
 * each sum with the firing threshold.
 */
`timescale 1ns/1ps
`default_nettype none

module recallUnit (
	input  wire                     clk_i,
	input  wire                     rst_n_i,
	input  wire                     rdEn_i,
	input  wire                     last_i,
	input  crossbarPkg::neuronAddrT neuron_i,
	input  wire                     spike_i,
	input  crossbarPkg::weightT     weight_i,
	output crossbarPkg::spikeVecT   fireVec_o,
	output logic                    fireValid_o
);

	// Read strobe delayed to meet the returned data
	logic rdQ;
	logic lastQ;
	crossbarPkg::neuronAddrT neuronQ;

	crossbarPkg::potentialT potential;
	crossbarPkg::potentialT sum;
	// Fire bits gathered over the sweep
	crossbarPkg::spikeVecT fireAcc;
	crossbarPkg::spikeVecT nextVec;

	// Running sum and fire decision
	always_comb begin
		sum = potential + (spike_i ? crossbarPkg::potentialT'(weight_i) : '0);
		nextVec = fireAcc;
		nextVec[neuronQ] = (sum >= crossbarPkg::THRESHOLD);
	end

	// ------------------------------------------------------------------------
	// Accumulate and decide
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rdQ <= 1'b0;
			lastQ <= 1'b0;
			neuronQ <= '0;
			potential <= '0;
			fireAcc <= '0;
			fireVec_o <= '0;
			fireValid_o <= 1'b0;
		end else begin
			rdQ <= rdEn_i;
			lastQ <= last_i;
			neuronQ <= neuron_i;
			fireValid_o <= 1'b0;
			if (rdQ) begin
				if (lastQ) begin
					// End of this neuron's row
					potential <= '0;
					fireAcc <= nextVec;
					if (neuronQ == crossbarPkg::neuronAddrT'(crossbarPkg::NUM_NEURONS - 1)) begin
						fireVec_o <= nextVec;
						fireValid_o <= 1'b1;
					end
				end else begin
					potential <= sum;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/synapseWeightMem.sv
/*
 * Synapse weight memory
 * 64 weights in a register array, registered reads for recall,
 * learn and host, writes from the learn unit or the host.
 */
`timescale 1ns/1ps
`default_nettype none

module synapseWeightMem (
	input  wire                  clk_i,
	input  wire                  rst_n_i,
	// Recall read
	input  wire                  rclRdEn_i,
	input  crossbarPkg::synAddrT rclAddr_i,
	output crossbarPkg::weightT  rclWeight_o,
	// Learn read
	input  wire                  lrnRdEn_i,
	input  crossbarPkg::synAddrT lrnRdAddr_i,
	output crossbarPkg::weightT  lrnWeight_o,
	// Learn write-back
	input  wire                  lrnWrEn_i,
	input  crossbarPkg::synAddrT lrnWrAddr_i,
	input  crossbarPkg::weightT  lrnWrData_i,
	// Host access
	input  wire                  hostWrEn_i,
	input  wire                  hostRdEn_i,
	input  crossbarPkg::synAddrT hostAddr_i,
	input  crossbarPkg::weightT  hostWrData_i,
	output crossbarPkg::weightT  hostRdData_o
);

	crossbarPkg::weightT weights [crossbarPkg::NUM_SYN];

	// ------------------------------------------------------------------------
	// Array and write ports
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < crossbarPkg::NUM_SYN; i++) begin
				weights[i] <= '0;
			end
		end else if (lrnWrEn_i) begin
			weights[lrnWrAddr_i] <= lrnWrData_i;
		end else if (hostWrEn_i) begin
			// Host writes only while the core is idle
			weights[hostAddr_i] <= hostWrData_i;
		end
	end

	// ------------------------------------------------------------------------
	// Registered read ports
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rclWeight_o <= '0;
			lrnWeight_o <= '0;
			hostRdData_o <= '0;
		end else begin
			if (rclRdEn_i) begin
				rclWeight_o <= weights[rclAddr_i];
			end
			if (lrnRdEn_i) begin
				lrnWeight_o <= weights[lrnRdAddr_i];
			end
			// Data one cycle after the strobe
			if (hostRdEn_i) begin
				hostRdData_o <= weights[hostAddr_i];
			end
		end
	end

	// Host write only legal while no learn sweep runs
	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(lrnWrEn_i && hostWrEn_i))
		else $error("learn and host weight writes collide");

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Compile and run the crossbar core testbench with Verilator.
# Pass or fail comes from the pass message in sim.log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f files.f --top-module tbCrossbarCore \
	-o simCrossbar > sim.log 2>&1 \
	&& ./obj_dir/simCrossbar >> sim.log 2>&1

cat sim.log
grep -qx "NO ERRORS" sim.log && { echo "Simulation passed"; exit 0; } \
	|| { echo "Simulation failed"; exit 1; }

// File: tests/tbClkGen.sv
/*
 * Testbench clock and reset
 * 4 ns clock, active-low reset held for five cycles.
 */
`timescale 1ns/1ps
`default_nettype none

module tbClkGen (
	output logic clk_o,
	output logic rst_n_o
);

	localparam int HALF_PERIOD_NS = 2;
	localparam int RESET_CYCLES = 5;

	// Free-running clock
	initial begin
		clk_o = 1'b0;
		forever begin
			#(HALF_PERIOD_NS) clk_o = ~clk_o;
		end
	end

	// Release just after an edge
	initial begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		#1 rst_n_o = 1'b1;
	end

endmodule

`default_nettype wire

// File: tests/tbCrossbarCore.sv
/*
 * Crossbar core testbench
 * Directed tests for reset, recall, learning, saturation,
 * overlapped pattern loading and random back-to-back runs,
 * checked against a behavioral model of the core.
 */
`timescale 1ns/1ps
`default_nettype none

module tbCrossbarCore;

	localparam int CLK_PERIOD_NS = 4;
	// Fixed start-to-done latency
	localparam int RUN_CYCLES = 134;
	localparam int RUN_LIMIT = 200;
	// Cycle after start where the next pattern goes in during the learn sweep
	localparam int LOAD_AT = 80;
	localparam int RUN_COUNT = 10;
	localparam int HOST_CYCLES = 2 * (crossbarPkg::NUM_SYN + 1) + crossbarPkg::NUM_AXONS + 1;
	localparam int TOTAL_CYCLES = 10 + (crossbarPkg::NUM_SYN + 2)
		+ RUN_COUNT * (RUN_CYCLES + HOST_CYCLES + 4);
	localparam int WATCHDOG_NS = TOTAL_CYCLES * CLK_PERIOD_NS * 3 / 2;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	logic clk;
	logic rstN;

	// DUT inputs
	logic start_i;
	logic spikeWrEn_i;
	crossbarPkg::axonAddrT spikeAddr_i;
	logic spikeData_i;
	logic wtWrEn_i;
	logic wtRdEn_i;
	crossbarPkg::synAddrT wtAddr_i;
	crossbarPkg::weightT wtData_i;
	// DUT outputs
	crossbarPkg::weightT wtRdData_o;
	crossbarPkg::spikeVecT outSpikes_o;
	logic busy_o;
	logic done_o;

	// Reference model state
	crossbarPkg::weightT mdlWeight [crossbarPkg::NUM_SYN];
	logic [crossbarPkg::NUM_AXONS-1:0] mdlPat;
	crossbarPkg::spikeVecT mdlFire;

	int mismatchCount = 0;
	int failCount = 0;
	logic [31:0] lfsrState = 32'h0f34_51a1;

	tbClkGen i_clkGen (
		.clk_o(clk),
		.rst_n_o(rstN)
	);

	crossbarCore i_dut (
		.clk_i(clk),
		.rst_n_i(rstN),
		.start_i(start_i),
		.spikeWrEn_i(spikeWrEn_i),
		.spikeAddr_i(spikeAddr_i),
		.spikeData_i(spikeData_i),
		.wtWrEn_i(wtWrEn_i),
		.wtRdEn_i(wtRdEn_i),
		.wtAddr_i(wtAddr_i),
		.wtData_i(wtData_i),
		.wtRdData_o(wtRdData_o),
		.outSpikes_o(outSpikes_o),
		.busy_o(busy_o),
		.done_o(done_o)
	);

	// ------------------------------------------------------------------------
	// Random source and compare tasks
	// ------------------------------------------------------------------------
	// Galois LFSR stepped once per bit
	function automatic logic randBit();
		logic outBit;
		outBit = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (outBit) begin
			lfsrState = lfsrState ^ LFSR_TAPS;
		end
		return outBit;
	endfunction

	function automatic logic [31:0] randBits(input int width);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < width; i++) begin
			value = {value[30:0], randBit()};
		end
		return value;
	endfunction

	function automatic int synIdx(input int neuron, input int axon);
		return neuron * crossbarPkg::NUM_AXONS + axon;
	endfunction

	task automatic checkSpikes(input string name, input crossbarPkg::spikeVecT got,
			input crossbarPkg::spikeVecT exp);
		if (got !== exp) begin
			mismatchCount++;
			$display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic checkWeight(input string name, input crossbarPkg::weightT got,
			input crossbarPkg::weightT exp);
		if (got !== exp) begin
			mismatchCount++;
			$display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			mismatchCount++;
			$display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	// ------------------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------------------
	// Recall on the current pattern, then learning toward it
	task automatic modelRun();
		int sum;
		int idx;
		for (int n = 0; n < crossbarPkg::NUM_NEURONS; n++) begin
			sum = 0;
			for (int a = 0; a < crossbarPkg::NUM_AXONS; a++) begin
				if (mdlPat[a]) begin
					sum += int'(mdlWeight[synIdx(n, a)]);
				end
			end
			mdlFire[n] = (sum >= 200);
		end
		for (int n = 0; n < crossbarPkg::NUM_NEURONS; n++) begin
			for (int a = 0; a < crossbarPkg::NUM_AXONS; a++) begin
				idx = synIdx(n, a);
				// Silent neuron keeps its weights
				if (!mdlFire[n]) begin
					continue;
				end
				if (mdlPat[a] && mdlWeight[idx] != 8'd255) begin
					mdlWeight[idx] = mdlWeight[idx] + 8'd1;
				end else if (!mdlPat[a] && mdlWeight[idx] != 8'd0) begin
					mdlWeight[idx] = mdlWeight[idx] - 8'd1;
				end
			end
		end
	endtask

	// ------------------------------------------------------------------------
	// Host access
	// ------------------------------------------------------------------------
	task automatic writeAllWeights();
		for (int i = 0; i < crossbarPkg::NUM_SYN; i++) begin
			@(posedge clk);
			#1;
			wtWrEn_i = 1'b1;
			wtAddr_i = crossbarPkg::synAddrT'(i);
			wtData_i = mdlWeight[i];
		end
		@(posedge clk);
		#1;
		wtWrEn_i = 1'b0;
	endtask

	// Back-to-back reads with data compared one cycle after each strobe
	task automatic checkAllWeights();
		for (int i = 0; i <= crossbarPkg::NUM_SYN; i++) begin
			@(posedge clk);
			#1;
			if (i > 0) begin
				checkWeight($sformatf("wtRdData_o[%0d]", i - 1), wtRdData_o, mdlWeight[i - 1]);
			end
			if (i < crossbarPkg::NUM_SYN) begin
				wtRdEn_i = 1'b1;
				wtAddr_i = crossbarPkg::synAddrT'(i);
			end else begin
				wtRdEn_i = 1'b0;
			end
		end
	endtask

	task automatic loadPattern(input logic [crossbarPkg::NUM_AXONS-1:0] pat);
		for (int a = 0; a < crossbarPkg::NUM_AXONS; a++) begin
			@(posedge clk);
			#1;
			spikeWrEn_i = 1'b1;
			spikeAddr_i = crossbarPkg::axonAddrT'(a);
			spikeData_i = pat[a];
		end
		@(posedge clk);
		#1;
		spikeWrEn_i = 1'b0;
		mdlPat = pat;
	endtask

	// Start pulse, optional pattern load during learning, then full check
	task automatic runCore(input logic loadNext,
			input logic [crossbarPkg::NUM_AXONS-1:0] nextPat);
		int cycles;
		int axon;
		modelRun();
		@(posedge clk);
		#1;
		start_i = 1'b1;
		cycles = 0;
		do begin
			@(posedge clk);
			#1;
			cycles++;
			start_i = 1'b0;
			if (cycles == 1) begin
				checkBit("busy_o", busy_o, 1'b1);
			end
			axon = cycles - LOAD_AT;
			if (loadNext && axon >= 0 && axon < crossbarPkg::NUM_AXONS) begin
				spikeWrEn_i = 1'b1;
				spikeAddr_i = crossbarPkg::axonAddrT'(axon);
				spikeData_i = nextPat[axon];
			end else begin
				spikeWrEn_i = 1'b0;
			end
		end while (!done_o && cycles < RUN_LIMIT);
		if (loadNext) begin
			mdlPat = nextPat;
		end
		if (!done_o) begin
			failCount++;
			$display("done_o did not arrive within %0d cycles of start", RUN_LIMIT);
		end else if (cycles != RUN_CYCLES) begin
			failCount++;
			$display("done_o came %0d cycles after start instead of %0d", cycles, RUN_CYCLES);
		end
		checkBit("busy_o", busy_o, 1'b0);
		checkSpikes("outSpikes_o", outSpikes_o, mdlFire);
		// done_o is a single pulse
		@(posedge clk);
		#1;
		checkBit("done_o", done_o, 1'b0);
		checkAllWeights();
	endtask

	// ------------------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------------------
	task automatic testReset();
		checkBit("busy_o", busy_o, 1'b0);
		checkBit("done_o", done_o, 1'b0);
		checkSpikes("outSpikes_o", outSpikes_o, '0);
		checkAllWeights();
	endtask

	// Neurons 0 and 3 exactly at threshold, 1 and 2 just below
	task automatic testRecall();
		for (int i = 0; i < crossbarPkg::NUM_SYN; i++) begin
			mdlWeight[i] = 8'd0;
		end
		for (int a = 0; a < 8; a++) begin
			mdlWeight[synIdx(0, a)] = 8'd25;
			mdlWeight[synIdx(1, a)] = 8'd24;
			mdlWeight[synIdx(1, a + 8)] = 8'd100;
		end
		mdlWeight[synIdx(2, 3)] = 8'd199;
		mdlWeight[synIdx(2, 12)] = 8'd255;
		mdlWeight[synIdx(3, 0)] = 8'd200;
		writeAllWeights();
		loadPattern(16'h00ff);
		runCore(1'b0, '0);
		checkSpikes("outSpikes_o", outSpikes_o, 4'b1001);
	endtask

	// Neuron 0 sums to 140, the others fire
	task automatic testLearn();
		for (int n = 0; n < crossbarPkg::NUM_NEURONS; n++) begin
			for (int a = 0; a < crossbarPkg::NUM_AXONS; a++) begin
				mdlWeight[synIdx(n, a)] = crossbarPkg::weightT'(16 * n + a + 10);
			end
		end
		writeAllWeights();
		loadPattern(16'ha5a5);
		runCore(1'b0, '0);
		checkSpikes("outSpikes_o", outSpikes_o, 4'b1110);
	endtask

	task automatic testSaturation();
		for (int a = 0; a < crossbarPkg::NUM_AXONS; a++) begin
			mdlWeight[synIdx(0, a)] = (a % 8 < 4) ? 8'd255 : 8'd0;
			mdlWeight[synIdx(1, a)] = (a % 8 < 4) ? 8'd254 : 8'd1;
			mdlWeight[synIdx(2, a)] = 8'd10;
			mdlWeight[synIdx(3, a)] = 8'd10;
		end
		writeAllWeights();
		loadPattern(16'h0f0f);
		runCore(1'b0, '0);
		checkSpikes("outSpikes_o", outSpikes_o, 4'b0011);
	endtask

	// Second pattern loaded while the first one is being learned
	task automatic testOverlap();
		for (int i = 0; i < crossbarPkg::NUM_SYN; i++) begin
			mdlWeight[i] = crossbarPkg::weightT'(randBits(6));
		end
		writeAllWeights();
		loadPattern(16'h3c3c);
		runCore(1'b1, 16'hc3c3);
		runCore(1'b0, '0);
	endtask

	task automatic testRandomRuns();
		logic [31:0] patBits;
		for (int r = 0; r < 5; r++) begin
			for (int i = 0; i < crossbarPkg::NUM_SYN; i++) begin
				mdlWeight[i] = crossbarPkg::weightT'(randBits(6));
			end
			writeAllWeights();
			patBits = randBits(crossbarPkg::NUM_AXONS);
			loadPattern(patBits[crossbarPkg::NUM_AXONS-1:0]);
			runCore(1'b0, '0);
		end
	endtask

	// ------------------------------------------------------------------------
	// Main sequence and watchdog
	// ------------------------------------------------------------------------
	initial begin
		start_i = 1'b0;
		spikeWrEn_i = 1'b0;
		spikeAddr_i = '0;
		spikeData_i = 1'b0;
		wtWrEn_i = 1'b0;
		wtRdEn_i = 1'b0;
		wtAddr_i = '0;
		wtData_i = '0;
		mdlPat = '0;
		mdlFire = '0;
		for (int i = 0; i < crossbarPkg::NUM_SYN; i++) begin
			mdlWeight[i] = 8'd0;
		end
		@(posedge rstN);
		testReset();
		testRecall();
		testLearn();
		testSaturation();
		testOverlap();
		testRandomRuns();
		$display("Mismatches: %0d, other failures: %0d", mismatchCount, failCount);
		if (mismatchCount == 0 && failCount == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire
